// ==== icache_bypass_pkg.sv ====
//////////////////////////////////////////////////
// Shared sizes and types for the uncached fetch
// path. Import it where a size or type is needed.
//////////////////////////////////////////////////

package icache_bypass_pkg;

  // Number of fetch ports sharing the refill channel
  localparam int unsigned NR_FETCH_PORTS = 2;

  // Fetch and refill address width
  localparam int unsigned FETCH_AW = 32;

  // Width of one fetched instruction word
  localparam int unsigned FETCH_DW = 32;

  // Width of one refill line
  localparam int unsigned LINE_WIDTH = 128;

  // Byte offset bits within a word and within a line
  localparam int unsigned FETCH_ALIGN = $clog2(FETCH_DW / 8);
  localparam int unsigned LINE_ALIGN = $clog2(LINE_WIDTH / 8);

  localparam int unsigned WORDS_PER_LINE = LINE_WIDTH / FETCH_DW;

  // Most refill requests that may be outstanding at once
  localparam int unsigned RSP_QUEUE_DEPTH = 4;

  // A single port still needs one index bit
  localparam int unsigned PORT_IDX_W = (NR_FETCH_PORTS > 1) ? $clog2(NR_FETCH_PORTS) : 1;

  // One bit per fetch port, used one-hot for request owners
  typedef logic [NR_FETCH_PORTS-1:0] port_mask_t;

  // Binary index of a fetch port
  typedef logic [PORT_IDX_W-1:0] port_idx_t;

  // Life cycle of one uncached fetch on a port
  typedef enum logic [1:0] {
    Idle,
    RequestData,
    WaitResponse,
    PresentResponse
  } bypass_state_e;

endpackage

// ==== bypass_port_fsm.sv ====
//////////////////////////////////////////////////
// Fetch FSM of one port. Requests a line refill,
// waits for its response, extracts the addressed
// word and presents it with a one-cycle ready.
//////////////////////////////////////////////////

`timescale 1ns/1ns

module bypass_port_fsm (
  input  logic                                   clk_i,
  input  logic                                   rst_i,

  input  logic                                   inst_valid_i,
  input  logic [icache_bypass_pkg::FETCH_AW-1:0] inst_addr_i,
  output logic [icache_bypass_pkg::FETCH_DW-1:0] inst_data_o,
  output logic                                   inst_error_o,
  output logic                                   inst_ready_o,

  output logic                                   port_req_o,
  input  logic                                   port_gnt_i,

  input  logic                                     rsp_take_i,
  input  logic [icache_bypass_pkg::LINE_WIDTH-1:0] line_data_i,
  input  logic                                     line_error_i
);

  import icache_bypass_pkg::*;

  bypass_state_e state_d, state_q;

  // The refill line viewed as an array of fetch words
  logic [WORDS_PER_LINE-1:0][FETCH_DW-1:0] line_words;
  logic [FETCH_DW-1:0]                     sel_word;

  assign line_words = line_data_i;
  // The source holds the address stable until the ready pulse
  assign sel_word   = line_words[inst_addr_i[LINE_ALIGN-1:FETCH_ALIGN]];

  always_comb begin
    state_d      = state_q;
    port_req_o   = 1'b0;
    inst_ready_o = 1'b0;
    unique case (state_q)
      Idle: begin
        if (inst_valid_i) begin
          state_d = RequestData;
        end
      end
      RequestData: begin
        port_req_o = 1'b1;
        if (port_gnt_i) begin
          state_d = WaitResponse;
        end
      end
      WaitResponse: begin
        if (rsp_take_i) begin
          state_d = PresentResponse;
        end
      end
      // Served from the data register for exactly one cycle
      PresentResponse: begin
        inst_ready_o = 1'b1;
        state_d      = Idle;
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Loads on the edge where this port takes its line
  always_ff @(posedge clk_i) begin
    if (state_q == WaitResponse && rsp_take_i) begin
      inst_data_o  <= sel_word;
      inst_error_o <= line_error_i;
    end
  end

  // Each fetch ends in a single pulse and never in a level
  assert property (@(posedge clk_i) disable iff (rst_i) inst_ready_o |=> !inst_ready_o);

  // The arbiter only grants a port that is waiting to issue
  assert property (@(posedge clk_i) disable iff (rst_i)
    port_gnt_i |-> state_q == RequestData);

endmodule

// ==== fetch_rr_arbiter.sv ====
//////////////////////////////////////////////////
// Round-robin arbiter over the port requests.
// Drives the line-aligned refill request and
// pushes the owner of each accepted request.
//////////////////////////////////////////////////

`timescale 1ns/1ns

module fetch_rr_arbiter (
  input  logic                                   clk_i,
  input  logic                                   rst_i,

  input  icache_bypass_pkg::port_mask_t          port_req_i,
  input  logic [icache_bypass_pkg::NR_FETCH_PORTS-1:0][icache_bypass_pkg::FETCH_AW-1:0]
                                                 port_addr_i,
  output icache_bypass_pkg::port_mask_t          port_gnt_o,

  input  logic                                   queue_full_i,

  output logic                                   refill_req_valid_o,
  output logic [icache_bypass_pkg::FETCH_AW-1:0] refill_req_addr_o,
  input  logic                                   refill_req_ready_i,

  output logic                                   push_o,
  output icache_bypass_pkg::port_mask_t          owner_o
);

  import icache_bypass_pkg::*;

  port_idx_t rr_ptr_q;
  logic      lock_q;
  port_idx_t lock_idx_q;

  logic      pick_valid;
  port_idx_t pick_idx;
  port_idx_t sel_idx;
  port_idx_t next_ptr;
  logic      accept;

  // First requesting port at or after the pointer
  always_comb begin
    int unsigned cand;
    pick_valid = 1'b0;
    pick_idx   = rr_ptr_q;
    for (int unsigned k = 0; k < NR_FETCH_PORTS; k++) begin
      cand = (rr_ptr_q + k) % NR_FETCH_PORTS;
      if (!pick_valid && port_req_i[cand]) begin
        pick_valid = 1'b1;
        pick_idx   = port_idx_t'(cand);
      end
    end
  end

  // A request once shown stays on the same port until it is taken
  assign sel_idx = lock_q ? lock_idx_q : pick_idx;

  assign refill_req_valid_o = lock_q | (pick_valid & ~queue_full_i);
  assign refill_req_addr_o  = {port_addr_i[sel_idx][FETCH_AW-1:LINE_ALIGN], {LINE_ALIGN{1'b0}}};

  assign accept  = refill_req_valid_o & refill_req_ready_i;
  assign owner_o = port_mask_t'(1) << sel_idx;
  assign push_o  = accept;

  assign port_gnt_o = accept ? owner_o : '0;

  assign next_ptr = (sel_idx == port_idx_t'(NR_FETCH_PORTS - 1)) ? '0 : sel_idx + 1'b1;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_ptr_q   <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (accept) begin
      rr_ptr_q <= next_ptr;
      lock_q   <= 1'b0;
    end else if (refill_req_valid_o) begin
      lock_q     <= 1'b1;
      lock_idx_q <= sel_idx;
    end
  end

  // Needs the ports to keep their address while they wait
  assert property (@(posedge clk_i) disable iff (rst_i)
    refill_req_valid_o && !refill_req_ready_i |=>
      refill_req_valid_o && $stable(refill_req_addr_o) && $stable(owner_o));

endmodule

// ==== refill_order_queue.sv ====
//////////////////////////////////////////////////
// FIFO of one-hot owners of outstanding refills.
// Responses come back in order, so the head entry
// names the port that takes the current response.
//////////////////////////////////////////////////

`timescale 1ns/1ns

module refill_order_queue (
  input  logic                          clk_i,
  input  logic                          rst_i,

  input  logic                          push_i,
  input  icache_bypass_pkg::port_mask_t owner_i,
  output logic                          full_o,

  input  logic                          refill_rsp_valid_i,
  output logic                          refill_rsp_ready_o,
  output icache_bypass_pkg::port_mask_t rsp_sel_o
);

  import icache_bypass_pkg::*;

  typedef logic [$clog2(RSP_QUEUE_DEPTH)-1:0]   qptr_t;
  typedef logic [$clog2(RSP_QUEUE_DEPTH+1)-1:0] qcnt_t;

  port_mask_t mem_q [RSP_QUEUE_DEPTH];
  qptr_t      wr_ptr_q;
  qptr_t      rd_ptr_q;
  qcnt_t      count_q;
  logic       pop;

  assign full_o             = (count_q == qcnt_t'(RSP_QUEUE_DEPTH));
  assign refill_rsp_ready_o = (count_q != '0);
  assign pop                = refill_rsp_valid_i & refill_rsp_ready_o;

  // Only the port owning the head sees the response
  assign rsp_sel_o = pop ? mem_q[rd_ptr_q] : '0;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= owner_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == qptr_t'(RSP_QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == qptr_t'(RSP_QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the fill level alone
      if (push_i && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // The arbiter must hold back requests while the queue is full
  assert property (@(posedge clk_i) disable iff (rst_i) push_i |-> !full_o);

  // Memory only answers requests that were issued before
  assert property (@(posedge clk_i) disable iff (rst_i)
    refill_rsp_valid_i |-> refill_rsp_ready_o);

endmodule

// ==== icache_bypass.sv ====
//////////////////////////////////////////////////
// Uncached fetch path top level. Several fetch
// ports share one line refill channel. Connect
// the refill port to an in-order line memory.
//////////////////////////////////////////////////

`timescale 1ns/1ns

module icache_bypass (
  input  logic                                       clk_i,
  input  logic                                       rst_i,

  input  logic [icache_bypass_pkg::NR_FETCH_PORTS-1:0]                  inst_valid_i,
  input  logic [icache_bypass_pkg::NR_FETCH_PORTS-1:0][icache_bypass_pkg::FETCH_AW-1:0]
                                                                        inst_addr_i,
  output logic [icache_bypass_pkg::NR_FETCH_PORTS-1:0][icache_bypass_pkg::FETCH_DW-1:0]
                                                                        inst_data_o,
  output logic [icache_bypass_pkg::NR_FETCH_PORTS-1:0]                  inst_error_o,
  output logic [icache_bypass_pkg::NR_FETCH_PORTS-1:0]                  inst_ready_o,

  output logic                                       refill_req_valid_o,
  output logic [icache_bypass_pkg::FETCH_AW-1:0]     refill_req_addr_o,
  input  logic                                       refill_req_ready_i,

  input  logic                                       refill_rsp_valid_i,
  input  logic [icache_bypass_pkg::LINE_WIDTH-1:0]   refill_rsp_data_i,
  input  logic                                       refill_rsp_error_i,
  output logic                                       refill_rsp_ready_o
);

  import icache_bypass_pkg::*;

  port_mask_t port_req;
  port_mask_t port_gnt;
  port_mask_t owner;
  port_mask_t rsp_sel;
  logic       push;
  logic       queue_full;

  // Line data and error go to every port and rsp_sel picks the taker
  for (genvar i = 0; i < NR_FETCH_PORTS; i++) begin : gen_port
    bypass_port_fsm i_bypass_port_fsm (
      .clk_i        ( clk_i              ),
      .rst_i        ( rst_i              ),
      .inst_valid_i ( inst_valid_i[i]    ),
      .inst_addr_i  ( inst_addr_i[i]     ),
      .inst_data_o  ( inst_data_o[i]     ),
      .inst_error_o ( inst_error_o[i]    ),
      .inst_ready_o ( inst_ready_o[i]    ),
      .port_req_o   ( port_req[i]        ),
      .port_gnt_i   ( port_gnt[i]        ),
      .rsp_take_i   ( rsp_sel[i]         ),
      .line_data_i  ( refill_rsp_data_i  ),
      .line_error_i ( refill_rsp_error_i )
    );
  end

  fetch_rr_arbiter i_fetch_rr_arbiter (
    .clk_i              ( clk_i              ),
    .rst_i              ( rst_i              ),
    .port_req_i         ( port_req           ),
    .port_addr_i        ( inst_addr_i        ),
    .port_gnt_o         ( port_gnt           ),
    .queue_full_i       ( queue_full         ),
    .refill_req_valid_o ( refill_req_valid_o ),
    .refill_req_addr_o  ( refill_req_addr_o  ),
    .refill_req_ready_i ( refill_req_ready_i ),
    .push_o             ( push               ),
    .owner_o            ( owner              )
  );

  // Remembers who owns each request in flight
  refill_order_queue i_refill_order_queue (
    .clk_i              ( clk_i              ),
    .rst_i              ( rst_i              ),
    .push_i             ( push               ),
    .owner_i            ( owner              ),
    .full_o             ( queue_full         ),
    .refill_rsp_valid_i ( refill_rsp_valid_i ),
    .refill_rsp_ready_o ( refill_rsp_ready_o ),
    .rsp_sel_o          ( rsp_sel            )
  );

endmodule

// ==== tb_bypass_checker.sv ====
//////////////////////////////////////////////////
// Checker for the uncached fetch path. Watches
// the DUT ports at the falling edge, predicts each
// fetched word and counts the mismatches.
//////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_bypass_checker (
  input  logic                                       clk_i,
  input  logic                                       rst_i,
  input  logic [icache_bypass_pkg::NR_FETCH_PORTS-1:0]                  inst_valid_i,
  input  logic [icache_bypass_pkg::NR_FETCH_PORTS-1:0][icache_bypass_pkg::FETCH_AW-1:0]
                                                                        inst_addr_i,
  input  logic [icache_bypass_pkg::NR_FETCH_PORTS-1:0][icache_bypass_pkg::FETCH_DW-1:0]
                                                                        inst_data_i,
  input  logic [icache_bypass_pkg::NR_FETCH_PORTS-1:0]                  inst_error_i,
  input  logic [icache_bypass_pkg::NR_FETCH_PORTS-1:0]                  inst_ready_i,
  input  logic                                       refill_req_valid_i,
  input  logic [icache_bypass_pkg::FETCH_AW-1:0]     refill_req_addr_i,
  input  logic                                       refill_req_ready_i,
  input  logic                                       refill_rsp_valid_i,
  input  logic                                       refill_rsp_ready_i,
  output int                                         error_count_o,
  output int                                         check_count_o
);

  import icache_bypass_pkg::*;

  logic [NR_FETCH_PORTS-1:0]               pending;
  logic [NR_FETCH_PORTS-1:0][FETCH_AW-1:0] pend_addr;
  logic                                    fetch_seen;
  logic                                    prev_stall;
  logic [FETCH_AW-1:0]                     prev_addr;
  int                                      outstanding;
  int                                      err_cnt = 0;
  int                                      chk_cnt = 0;

  assign error_count_o = err_cnt;
  assign check_count_o = chk_cnt;

  // The word address with its top byte inverted
  function automatic logic [FETCH_DW-1:0] expected_word(input logic [FETCH_AW-1:0] a);
    logic [31:0] w;
    w = {a[31:2], 2'b00};
    return {~w[31:24], w[23:0]};
  endfunction

  task automatic report_value(input string sig, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("CHECK FAILED at %0t: %s got %h expected %h", $time, sig, got, exp);
    err_cnt++;
  endtask

  task automatic report_event(input string msg);
    $display("Error at %0t: %s", $time, msg);
    err_cnt++;
  endtask

  always @(negedge clk_i) begin
    logic matched;
    if (rst_i) begin
      pending     = '0;
      fetch_seen  = 1'b0;
      prev_stall  = 1'b0;
      outstanding = 0;
    end else begin
      if (!fetch_seen) begin
        chk_cnt++;
        if (inst_ready_i != '0 || refill_req_valid_i || refill_rsp_ready_i) begin
          report_event("DUT outputs active before the first fetch");
        end
        fetch_seen = (inst_valid_i != '0);
      end
      // Responses are taken exactly while requests are outstanding
      chk_cnt++;
      if (refill_rsp_ready_i != (outstanding != 0)) begin
        report_value("refill_rsp_ready_o", 32'(refill_rsp_ready_i),
                     32'(outstanding != 0));
      end
      if (refill_req_valid_i) begin
        chk_cnt++;
        if (refill_req_addr_i[LINE_ALIGN-1:0] != '0) begin
          report_value("refill_req_addr_o", refill_req_addr_i,
                       {refill_req_addr_i[FETCH_AW-1:LINE_ALIGN], {LINE_ALIGN{1'b0}}});
        end
      end
      // A stalled request must come back unchanged
      if (prev_stall) begin
        chk_cnt++;
        if (!refill_req_valid_i || refill_req_addr_i != prev_addr) begin
          report_event("refill request dropped or changed while stalled");
        end
      end
      prev_stall = refill_req_valid_i && !refill_req_ready_i;
      prev_addr  = refill_req_addr_i;
      if (refill_req_valid_i && refill_req_ready_i) begin
        matched = 1'b0;
        for (int i = 0; i < NR_FETCH_PORTS; i++) begin
          if (pending[i] && pend_addr[i][FETCH_AW-1:LINE_ALIGN] ==
              refill_req_addr_i[FETCH_AW-1:LINE_ALIGN]) begin
            matched = 1'b1;
          end
        end
        chk_cnt++;
        if (!matched) begin
          report_event("accepted refill request matches no pending fetch");
        end
        outstanding++;
      end
      if (refill_rsp_valid_i && refill_rsp_ready_i) begin
        outstanding--;
      end
      chk_cnt++;
      if (outstanding < 0 || outstanding > int'(RSP_QUEUE_DEPTH)) begin
        report_event($sformatf("%0d refill requests outstanding", outstanding));
      end
      for (int i = 0; i < NR_FETCH_PORTS; i++) begin
        if (inst_ready_i[i]) begin
          if (!pending[i]) begin
            report_event($sformatf("port %0d ready pulse without a pending fetch", i));
          end else begin
            chk_cnt += 2;
            if (inst_data_i[i] != expected_word(pend_addr[i])) begin
              report_value($sformatf("inst_data_o[%0d]", i), inst_data_i[i],
                           expected_word(pend_addr[i]));
            end
            if (inst_error_i[i] != pend_addr[i][12]) begin
              report_value($sformatf("inst_error_o[%0d]", i), 32'(inst_error_i[i]),
                           32'(pend_addr[i][12]));
            end
          end
          pending[i] = 1'b0;
        end else if (inst_valid_i[i] && !pending[i]) begin
          pending[i]   = 1'b1;
          pend_addr[i] = inst_addr_i[i];
        end
      end
    end
  end

endmodule

// ==== tb_icache_bypass.sv ====
//////////////////////////////////////////////////
// Testbench top for the uncached fetch path.
// Drives random fetches on every port, models an
// in-order line memory and reports the verdict.
//////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_icache_bypass;

  import icache_bypass_pkg::*;

  localparam int unsigned STIM_CYCLES   = 3000;
  localparam int unsigned FETCH_TIMEOUT = 200;
  localparam int unsigned DRAIN_LIMIT   = 400;
  localparam logic [31:0] SEED          = 32'd87;

  logic                                         clk;
  logic                                         rst;
  logic [NR_FETCH_PORTS-1:0]                    inst_valid;
  logic [NR_FETCH_PORTS-1:0][FETCH_AW-1:0]      inst_addr;
  logic [NR_FETCH_PORTS-1:0][FETCH_DW-1:0]      inst_data;
  logic [NR_FETCH_PORTS-1:0]                    inst_error;
  logic [NR_FETCH_PORTS-1:0]                    inst_ready;
  logic                                         refill_req_valid;
  logic [FETCH_AW-1:0]                          refill_req_addr;
  logic                                         refill_req_ready;
  logic                                         refill_rsp_valid;
  logic [LINE_WIDTH-1:0]                        refill_rsp_data;
  logic                                         refill_rsp_error;
  logic                                         refill_rsp_ready;

  // Line addresses accepted by the memory model in request order
  logic [FETCH_AW-1:0] mem_q [$];
  int unsigned         rsp_delay;
  logic [31:0]         rng;

  logic [NR_FETCH_PORTS-1:0] busy;
  logic [NR_FETCH_PORTS-1:0] done;
  int unsigned               wait_cnt [NR_FETCH_PORTS];
  int unsigned               timeout_count;
  logic                      hung;
  int                        error_count;
  int                        check_count;

  always #50 clk = ~clk;

  icache_bypass i_dut (
    .clk_i              ( clk              ),
    .rst_i              ( rst              ),
    .inst_valid_i       ( inst_valid       ),
    .inst_addr_i        ( inst_addr        ),
    .inst_data_o        ( inst_data        ),
    .inst_error_o       ( inst_error       ),
    .inst_ready_o       ( inst_ready       ),
    .refill_req_valid_o ( refill_req_valid ),
    .refill_req_addr_o  ( refill_req_addr  ),
    .refill_req_ready_i ( refill_req_ready ),
    .refill_rsp_valid_i ( refill_rsp_valid ),
    .refill_rsp_data_i  ( refill_rsp_data  ),
    .refill_rsp_error_i ( refill_rsp_error ),
    .refill_rsp_ready_o ( refill_rsp_ready )
  );

  tb_bypass_checker i_checker (
    .clk_i              ( clk              ),
    .rst_i              ( rst              ),
    .inst_valid_i       ( inst_valid       ),
    .inst_addr_i        ( inst_addr        ),
    .inst_data_i        ( inst_data        ),
    .inst_error_i       ( inst_error       ),
    .inst_ready_i       ( inst_ready       ),
    .refill_req_valid_i ( refill_req_valid ),
    .refill_req_addr_i  ( refill_req_addr  ),
    .refill_req_ready_i ( refill_req_ready ),
    .refill_rsp_valid_i ( refill_rsp_valid ),
    .refill_rsp_ready_i ( refill_rsp_ready ),
    .error_count_o      ( error_count      ),
    .check_count_o      ( check_count      )
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Picks a word in one of four lines and varies bit 12 and the top byte
  function automatic logic [FETCH_AW-1:0] fetch_addr(input logic [31:0] r);
    return {(r[6] ? 8'h41 : 8'h00), 11'h0, r[4], 6'h0, r[3:0], 2'b00};
  endfunction

  // Word k of the line at a is a + 4k with its top byte inverted
  function automatic logic [LINE_WIDTH-1:0] line_at(input logic [FETCH_AW-1:0] a);
    logic [LINE_WIDTH-1:0] line;
    logic [31:0]           w;
    for (int k = 0; k < WORDS_PER_LINE; k++) begin
      w = a + 32'(4 * k);
      line[k*FETCH_DW +: FETCH_DW] = {~w[31:24], w[23:0]};
    end
    return line;
  endfunction

  // Drives one clock cycle after the rising edge and observes it at the falling edge
  task automatic run_cycle(input logic allow_start);
    @(posedge clk);
    #10;
    if (mem_q.size() != 0 && rsp_delay == 0) begin
      refill_rsp_valid = 1'b1;
      refill_rsp_data  = line_at(mem_q[0]);
      refill_rsp_error = mem_q[0][12];
    end else begin
      refill_rsp_valid = 1'b0;
      refill_rsp_data  = '0;
      refill_rsp_error = 1'b0;
      if (mem_q.size() != 0) begin
        rsp_delay--;
      end
    end
    rng = xorshift32(rng);
    refill_req_ready = (rng[1:0] != 2'b00);
    for (int i = 0; i < NR_FETCH_PORTS; i++) begin
      if (done[i]) begin
        inst_valid[i] = 1'b0;
        busy[i]       = 1'b0;
        done[i]       = 1'b0;
      end else if (!busy[i] && allow_start) begin
        rng = xorshift32(rng);
        if (rng[1:0] == 2'b00) begin
          rng           = xorshift32(rng);
          inst_addr[i]  = fetch_addr(rng);
          inst_valid[i] = 1'b1;
          busy[i]       = 1'b1;
          wait_cnt[i]   = 0;
        end
      end
    end
    @(negedge clk);
    if (refill_req_valid && refill_req_ready) begin
      mem_q.push_back(refill_req_addr);
    end
    if (refill_rsp_valid && refill_rsp_ready) begin
      void'(mem_q.pop_front());
      rng       = xorshift32(rng);
      rsp_delay = rng % 4;
    end
    for (int i = 0; i < NR_FETCH_PORTS; i++) begin
      if (busy[i] && !done[i]) begin
        if (inst_ready[i]) begin
          done[i] = 1'b1;
        end else begin
          wait_cnt[i]++;
          if (wait_cnt[i] > FETCH_TIMEOUT && !hung) begin
            $display("Port %0d fetch of %h did not complete within %0d cycles",
                     i, inst_addr[i], FETCH_TIMEOUT);
            timeout_count++;
            hung = 1'b1;
          end
        end
      end
    end
  endtask

  initial begin
    int unsigned n;
    clk              = 1'b0;
    rst              = 1'b1;
    rng              = SEED;
    inst_valid       = '0;
    inst_addr        = '0;
    refill_req_ready = 1'b0;
    refill_rsp_valid = 1'b0;
    refill_rsp_data  = '0;
    refill_rsp_error = 1'b0;
    busy             = '0;
    done             = '0;
    hung             = 1'b0;
    timeout_count    = 0;
    rsp_delay        = 0;
    for (int i = 0; i < NR_FETCH_PORTS; i++) begin
      wait_cnt[i] = 0;
    end
    repeat (10) @(posedge clk);
    #10;
    rst = 1'b0;
    // A few quiet cycles so the idle outputs after reset get observed
    for (n = 0; n < 5; n++) begin
      run_cycle(1'b0);
    end
    for (n = 0; n < STIM_CYCLES && !hung; n++) begin
      run_cycle(1'b1);
    end
    n = 0;
    while ((busy != '0 || mem_q.size() != 0) && !hung) begin
      if (n >= DRAIN_LIMIT) begin
        $display("Outstanding fetches did not drain within %0d cycles", DRAIN_LIMIT);
        timeout_count++;
        hung = 1'b1;
      end else begin
        run_cycle(1'b0);
        n++;
      end
    end
    $display("Checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count,
             timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
icache_bypass_pkg.sv
bypass_port_fsm.sv
fetch_rr_arbiter.sv
refill_order_queue.sv
icache_bypass.sv
tb_bypass_checker.sv
tb_icache_bypass.sv

// ==== Bender.yml ====
package:
  name: icache_bypass

sources:
  - icache_bypass_pkg.sv
  - bypass_port_fsm.sv
  - fetch_rr_arbiter.sv
  - refill_order_queue.sv
  - icache_bypass.sv
  - target: test
    files:
      - tb_bypass_checker.sv
      - tb_icache_bypass.sv
